/* sim.f */
hdl/gamepad_pkg.sv
hdl/nes_poller.sv
hdl/pmod_receiver.sv
hdl/button_merge.sv
hdl/gamepad_top.sv
test/gamepad_checker.sv
test/gamepad_tb.sv

/* Makefile */
TOP = gamepad_tb

.PHONY: all lint clean

# build, run and look for the pass line in the output
all:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f sim.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "all tests passed"

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f sim.f

clean:
	rm -rf obj_dir

/* test/gamepad_tb.sv */
`timescale 1ns/10ps

// nes pad model, pmod driver and test sequence around gamepad_top
module gamepad_tb;
    import gamepad_pkg::*;

    localparam int LATCH_CYCLES   = 20;
    localparam int HALF_CYCLES    = 10;
    localparam int POLL_CYCLES    = (LATCH_CYCLES + 1) + (HALF_CYCLES + 1)
                                    + (NES_BITS - 1) * (LATCH_CYCLES + 1); // 179
    localparam int TIMEOUT_CYCLES = 12 * POLL_CYCLES + 352; // 2500 with reset and slack
    localparam logic [15:0] SEED  = 16'd22404;

    logic           clk = 1'b0;
    logic           rst_n;
    logic           nes_data;
    logic           nes_latch;
    logic           nes_clk;
    logic           pmod_data;
    logic           pmod_clk;
    logic           pmod_latch;
    nes_buttons_t   buttons;
    extra_buttons_t extra_buttons;
    logic           snes_active;

    nes_buttons_t   nes_pattern;             // pressed state the pad shows
    snes_frame_t    snes_sent;               // last complete pmod frame
    nes_buttons_t   pad_bits    = '0;        // pad shift register with 1 for pressed
    logic           pad_latch_q = 1'b0;
    logic           pad_clk_q   = 1'b0;
    logic [15:0]    lfsr;
    int             cycle_count = 0;
    int             check_count;
    int             error_count;
    int             test_num;
    int             tests_bad;
    int             check_base;
    int             error_base;

    always #4 clk = ~clk; // 8 ns

    gamepad_top #(
        .LATCH_CYCLES (LATCH_CYCLES),
        .HALF_CYCLES  (HALF_CYCLES)
    ) DUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .nes_data      (nes_data),
        .nes_latch     (nes_latch),
        .nes_clk       (nes_clk),
        .pmod_data     (pmod_data),
        .pmod_clk      (pmod_clk),
        .pmod_latch    (pmod_latch),
        .buttons       (buttons),
        .extra_buttons (extra_buttons),
        .snes_active   (snes_active)
    );

    gamepad_checker #(
        .LATCH_CYCLES (LATCH_CYCLES),
        .HALF_CYCLES  (HALF_CYCLES)
    ) u_checker (
        .clk           (clk),
        .rst_n         (rst_n),
        .nes_latch     (nes_latch),
        .nes_clk       (nes_clk),
        .buttons       (buttons),
        .extra_buttons (extra_buttons),
        .snes_active   (snes_active),
        .nes_pattern   (nes_pattern),
        .snes_sent     (snes_sent),
        .check_count   (check_count),
        .error_count   (error_count)
    );

    // nes pad loads on falling latch and shifts on rising clock
    assign nes_data = ~pad_bits[0]; // low = pressed

    always @(negedge clk) begin
        pad_latch_q <= nes_latch;
        pad_clk_q   <= nes_clk;
        if (pad_latch_q && !nes_latch) begin
            pad_bits <= nes_pattern; // A on the wire now
        end else if (nes_clk && !pad_clk_q) begin
            pad_bits <= {1'b0, pad_bits[NES_BITS-1:1]}; // next button with released fill
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("tests failed");
            $finish;
        end
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [15:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr); // one step per bit
            val  = {val[14:0], lfsr[0]};
        end
    endtask

    // one snes only button plus one random pick that may land on the same bit
    task automatic make_light_frame(output snes_frame_t frame);
        logic [15:0] r;
        logic [3:0]  pos;
        frame = '0;
        take_bits(2, r);
        case (r[1:0])
            2'd0:    frame[SNES_IDX_X] = 1'b1;
            2'd1:    frame[SNES_IDX_Y] = 1'b1;
            2'd2:    frame[SNES_IDX_L] = 1'b1;
            default: frame[SNES_IDX_R] = 1'b1;
        endcase
        take_bits(4, r);
        pos        = 4'(r % SNES_BITS);
        frame[pos] = 1'b1;
    endtask

    // more than GHOST_LIMIT pressed but never all ones
    task automatic make_ghost_frame(output snes_frame_t frame);
        logic [15:0] r;
        logic [3:0]  pos;
        take_bits(SNES_BITS, r);
        frame = r[SNES_BITS-1:0];
        while ($countones(frame) <= GHOST_LIMIT) begin
            take_bits(4, r);
            pos        = 4'(r % SNES_BITS);
            frame[pos] = 1'b1;
        end
        if (&frame) begin
            frame[SNES_IDX_START] = 1'b0; // all ones would read as no pad
        end
    endtask

    // B first, each level held 4 clocks, then a latch pulse
    task automatic send_frame(input snes_frame_t frame);
        for (int i = SNES_BITS - 1; i >= 0; i--) begin
            pmod_data = frame[i];
            pmod_clk  = 1'b0;
            repeat (4) @(negedge clk);
            pmod_clk = 1'b1;
            repeat (4) @(negedge clk);
        end
        pmod_clk   = 1'b0;
        pmod_latch = 1'b1;
        repeat (4) @(negedge clk);
        pmod_latch = 1'b0;
        repeat (4) @(negedge clk); // frame register loaded by now
        snes_sent = frame;
    endtask

    // returns once the checker has compared the finished poll
    task automatic wait_poll_end();
        @(posedge nes_latch);
        @(negedge clk);
        @(negedge clk);
    endtask

    // new nes pattern and maybe a frame, then one full poll
    task automatic run_step(input logic send, input snes_frame_t frame);
        logic [15:0] r;
        take_bits(NES_BITS, r);
        nes_pattern = r[NES_BITS-1:0];
        if (send) begin
            send_frame(frame);
        end
        wait_poll_end();
    endtask

    task automatic close_test(input string name);
        int checks;
        int errors;
        checks = check_count - check_base;
        errors = error_count - error_base;
        test_num++;
        if (checks == 0) begin
            tests_bad++;
            $display("test %0d %s: no check was made", test_num, name);
        end else begin
            if (errors != 0) begin
                tests_bad++;
            end
            $display("test %0d %s: %0d checks, %0d errors", test_num, name, checks, errors);
        end
        check_base = check_count;
        error_base = error_count;
    endtask

    initial begin
        snes_frame_t frame;
        rst_n       = 1'b0;
        pmod_data   = 1'b0;
        pmod_clk    = 1'b0;
        pmod_latch  = 1'b0;
        nes_pattern = '0;
        snes_sent   = '1; // nothing plugged in yet
        lfsr        = SEED;
        test_num    = 0;
        tests_bad   = 0;
        check_base  = 0;
        error_base  = 0;

        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        repeat (2) @(negedge clk);
        close_test("reset");

        wait_poll_end(); // first poll already under way
        wait_poll_end();
        close_test("nes poll shape");

        repeat (4) run_step(1'b0, '1);
        close_test("nes buttons");

        repeat (2) begin
            make_light_frame(frame);
            run_step(1'b1, frame);
        end
        close_test("snes override");

        repeat (2) begin
            make_ghost_frame(frame);
            run_step(1'b1, frame);
        end
        close_test("ghost filter");

        run_step(1'b1, '1); // pad unplugged
        run_step(1'b0, '1);
        close_test("nes fallback");

        $display("tests %0d, bad %0d, checks %0d, errors %0d",
                 test_num, tests_bad, check_count, error_count);
        if (tests_bad == 0 && error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* test/gamepad_checker.sv */
`timescale 1ns/10ps

// watches the DUT pins and outputs and compares them with the merge rules
module gamepad_checker #(
    parameter int LATCH_CYCLES = 300,
    parameter int HALF_CYCLES  = 150
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        nes_latch,
    input  logic                        nes_clk,
    input  gamepad_pkg::nes_buttons_t   buttons,
    input  gamepad_pkg::extra_buttons_t extra_buttons,
    input  logic                        snes_active,
    input  gamepad_pkg::nes_buttons_t   nes_pattern, // what the pad model holds
    input  gamepad_pkg::snes_frame_t    snes_sent,   // last frame fully sent
    output int                          check_count,
    output int                          error_count
);
    import gamepad_pkg::*;

    localparam int LATCH_WIDTH = LATCH_CYCLES + 1;
    localparam int PULSE_WIDTH = HALF_CYCLES + 1;
    localparam int PULSES      = NES_BITS - 1; // A needs no pulse

    logic         latch_q;
    logic         clk_q;
    logic         rst_q      = 1'b0;
    logic         seen_fall;          // at least one poll under way
    int           latch_len;          // cycles latch has been high
    int           clk_len;            // cycles nes_clk has been high
    int           pulse_cnt;          // pulses since latch fell
    int           rst_cycles = 0;
    int           checks     = 0;
    int           errors     = 0;
    nes_buttons_t polled;             // pattern loaded for the running poll
    logic [12:0]  got_out;
    logic [12:0]  exp_out;

    // {snes_active, extra_buttons, buttons} for one nes pattern and frame
    function automatic logic [12:0] expected_outputs(input nes_buttons_t nes,
                                                      input snes_frame_t  frame);
        nes_buttons_t   common;
        extra_buttons_t extra;
        common = '0;
        extra  = '0;
        if (frame == '1) begin
            return {1'b0, 4'h0, nes}; // no pad so nes drives and no extras
        end
        if ($countones(frame) <= GHOST_LIMIT) begin // believable frame
            common = {frame[SNES_IDX_RIGHT], frame[SNES_IDX_LEFT], frame[SNES_IDX_DOWN],
                      frame[SNES_IDX_UP], frame[SNES_IDX_START], frame[SNES_IDX_SELECT],
                      frame[SNES_IDX_B], frame[SNES_IDX_A]};
            extra  = {frame[SNES_IDX_R], frame[SNES_IDX_L], frame[SNES_IDX_Y],
                      frame[SNES_IDX_X]};
        end
        return {1'b1, extra, common};
    endfunction

    // pins and merged outputs against one expected value
    task automatic compare_outputs(input string when, input logic [14:0] want);
        checks++;
        if ({nes_latch, nes_clk, got_out} !== want) begin
            errors++;
            $write("ERROR %0t: %s, latch %b clk %b active %b extra %h buttons %h",
                   $time, when, nes_latch, nes_clk, got_out[12], got_out[11:8], got_out[7:0]);
            $display(", expected %b %b %b %h %h",
                     want[14], want[13], want[12], want[11:8], want[7:0]);
        end
    endtask

    task automatic compare_count(input string what, input int got, input int want);
        checks++;
        if (got != want) begin
            errors++;
            $display("ERROR %0t: %s is %0d, expected %0d", $time, what, got, want);
        end
    endtask

    assign got_out     = {snes_active, extra_buttons, buttons};
    assign exp_out     = expected_outputs(polled, snes_sent);
    assign check_count = checks;
    assign error_count = errors;

    always @(posedge clk) begin
        if (!rst_n) begin
            latch_q    <= 1'b0;
            clk_q      <= 1'b0;
            seen_fall  <= 1'b0;
            latch_len  <= 0;
            clk_len    <= 0;
            pulse_cnt  <= 0;
            polled     <= '0;
            rst_cycles <= rst_cycles + 1;
            if (rst_cycles > 0) begin
                compare_outputs("in reset", '0); // registers loaded by the first edge
            end
        end else begin
            latch_q <= nes_latch;
            clk_q   <= nes_clk;
            if (!rst_q) begin
                compare_outputs("after reset", '0);
            end
            if (nes_latch) begin
                latch_len <= latch_q ? latch_len + 1 : 1;
            end
            if (latch_q && !nes_latch) begin // latch fell and the pad loads here
                compare_count("latch width", latch_len, LATCH_WIDTH);
                polled    <= nes_pattern;
                pulse_cnt <= 0;
                seen_fall <= 1'b1;
            end
            if (nes_clk) begin
                clk_len <= clk_q ? clk_len + 1 : 1;
            end
            if (nes_clk && !clk_q) begin
                pulse_cnt <= pulse_cnt + 1;
            end
            if (clk_q && !nes_clk) begin
                compare_count("nes_clk pulse width", clk_len, PULSE_WIDTH);
            end
            if (nes_latch && !latch_q && seen_fall) begin // poll complete
                compare_count("nes_clk pulses per poll", pulse_cnt, PULSES);
                compare_outputs("end of poll", {2'b10, exp_out});
            end
        end
        rst_q <= rst_n;
    end

endmodule

/* hdl/gamepad_top.sv */
`timescale 1ns/10ps

// nes poller and pmod receiver feeding the merge stage
module gamepad_top #(
    parameter int LATCH_CYCLES = 300, // 12 us at 25 MHz
    parameter int HALF_CYCLES  = 150  // 6 us at 25 MHz
) (
    input  logic                        clk,
    input  logic                        rst_n,

    // nes pad, we drive latch and clock
    input  logic                        nes_data,
    output logic                        nes_latch,
    output logic                        nes_clk,

    // pmod adapter drives everything
    input  logic                        pmod_data,
    input  logic                        pmod_clk,
    input  logic                        pmod_latch,

    output gamepad_pkg::nes_buttons_t   buttons,
    output gamepad_pkg::extra_buttons_t extra_buttons,
    output logic                        snes_active   // 1 = snes is the source
);
    import gamepad_pkg::*;

    nes_buttons_t nes_buttons;
    snes_frame_t  snes_frame;

    nes_poller #(
        .LATCH_CYCLES (LATCH_CYCLES),
        .HALF_CYCLES  (HALF_CYCLES)
    ) u_nes_poller (
        .clk         (clk),
        .rst_n       (rst_n),
        .nes_data    (nes_data),
        .nes_latch   (nes_latch),
        .nes_clk     (nes_clk),
        .nes_buttons (nes_buttons)
    );

    pmod_receiver u_pmod_receiver (
        .clk        (clk),
        .rst_n      (rst_n),
        .pmod_data  (pmod_data),
        .pmod_clk   (pmod_clk),
        .pmod_latch (pmod_latch),
        .snes_frame (snes_frame)
    );

    button_merge u_button_merge (
        .snes_frame    (snes_frame),
        .nes_buttons   (nes_buttons),
        .buttons       (buttons),
        .extra_buttons (extra_buttons),
        .snes_active   (snes_active)
    );

endmodule

/* hdl/button_merge.sv */
`timescale 1ns/10ps

// picks snes when a pad is present, else nes
// corrupt snes frames read as nothing pressed
module button_merge (
    input  gamepad_pkg::snes_frame_t    snes_frame,
    input  gamepad_pkg::nes_buttons_t   nes_buttons,
    output gamepad_pkg::nes_buttons_t   buttons,
    output gamepad_pkg::extra_buttons_t extra_buttons,
    output logic                        snes_active
);
    import gamepad_pkg::*;

    localparam int CNT_W = $clog2(SNES_BITS + 1);
    localparam logic [CNT_W-1:0] LIMIT = CNT_W'(GHOST_LIMIT);

    logic             present;     // some bit low
    logic [CNT_W-1:0] press_count; // ones in frame
    logic             ghost;
    snes_frame_t      filtered;
    nes_buttons_t     snes_common; // frame remapped to nes order

    assign present = ~&snes_frame; // all ones = nothing plugged in

    always_comb begin
        press_count = '0;
        for (int i = 0; i < SNES_BITS; i++) begin
            press_count = press_count + CNT_W'(snes_frame[i]);
        end
    end

    assign ghost    = (press_count > LIMIT);
    assign filtered = (present && !ghost) ? snes_frame : '0;

    // common buttons in nes bit order
    assign snes_common = {
        filtered[SNES_IDX_RIGHT],
        filtered[SNES_IDX_LEFT],
        filtered[SNES_IDX_DOWN],
        filtered[SNES_IDX_UP],
        filtered[SNES_IDX_START],
        filtered[SNES_IDX_SELECT],
        filtered[SNES_IDX_B],
        filtered[SNES_IDX_A]
    };

    assign buttons     = present ? snes_common : nes_buttons;
    assign snes_active = present;

    // nes has no X/Y/L/R
    assign extra_buttons = present ? {filtered[SNES_IDX_R],
                                      filtered[SNES_IDX_L],
                                      filtered[SNES_IDX_Y],
                                      filtered[SNES_IDX_X]} : '0;

    // nes source never reports X/Y/L/R
    always_comb begin
        a_extra_idle: assert final (snes_active || (extra_buttons == '0))
            else $error("extra buttons set while nes is the source");
    end

endmodule

/* hdl/pmod_receiver.sv */
`timescale 1ns/10ps

// serial receiver for the snes gamepad pmod
// adapter drives all three wires, we only sample
module pmod_receiver (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     pmod_data,
    input  logic                     pmod_clk,
    input  logic                     pmod_latch,
    output gamepad_pkg::snes_frame_t snes_frame
);
    import gamepad_pkg::*;

    logic [1:0]  data_sync;  // two flop synchronisers
    logic [1:0]  clk_sync;
    logic [1:0]  latch_sync;
    logic        clk_prev;   // last synchronised level
    logic        latch_prev;
    logic        clk_rise;
    logic        latch_rise;
    snes_frame_t shift_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data_sync  <= '0;
            clk_sync   <= '0;
            latch_sync <= '0;
            clk_prev   <= 1'b0;
            latch_prev <= 1'b0;
        end else begin
            data_sync  <= {data_sync[0], pmod_data};
            clk_sync   <= {clk_sync[0], pmod_clk};
            latch_sync <= {latch_sync[0], pmod_latch};
            clk_prev   <= clk_sync[1];
            latch_prev <= latch_sync[1];
        end
    end

    assign clk_rise   = clk_sync[1] & ~clk_prev;
    assign latch_rise = latch_sync[1] & ~latch_prev;

    // shift in at bit 0, first bit sent ends up in bit 11
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            shift_q    <= '1; // all ones reads as no pad
            snes_frame <= '1;
        end else begin
            if (clk_rise) begin
                shift_q <= {shift_q[SNES_BITS-2:0], data_sync[1]};
            end
            if (latch_rise) begin
                snes_frame <= shift_q; // frame complete
            end
        end
    end

    // merge stage sees a frame only after a full latch
    a_frame_on_latch: assert property (
        @(posedge clk) disable iff (!rst_n)
        $changed(snes_frame) |-> $past(latch_rise)
    ) else $error("snes_frame changed without a latch edge");

endmodule

/* hdl/nes_poller.sv */
`timescale 1ns/10ps

// polls an 8 button nes pad
// latch pulse, then A read with clock low, then seven clock pulses
module nes_poller #(
    parameter int LATCH_CYCLES = 300, // 12 us at 25 MHz, also one pulse slot
    parameter int HALF_CYCLES  = 150  // 6 us at 25 MHz
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      nes_data,   // low = pressed
    output logic                      nes_latch,
    output logic                      nes_clk,
    output gamepad_pkg::nes_buttons_t nes_buttons // 1 = pressed
);
    import gamepad_pkg::*;

    localparam int CNT_W = $clog2(LATCH_CYCLES + 1);
    localparam int IDX_W = $clog2(NES_BITS);

    localparam logic [CNT_W-1:0] LATCH_END = CNT_W'(LATCH_CYCLES);
    localparam logic [CNT_W-1:0] HALF_END  = CNT_W'(HALF_CYCLES);
    localparam logic [IDX_W-1:0] LAST_IDX  = IDX_W'(NES_BITS - 1);

    poll_state_t      state;
    poll_state_t      state_nx;
    logic [CNT_W-1:0] count;    // cycles within current state or slot
    logic [CNT_W-1:0] count_nx;
    logic [IDX_W-1:0] idx;      // button being read
    logic [IDX_W-1:0] idx_nx;
    logic             sample;   // take nes_data this cycle

    always_comb begin
        state_nx = state;
        count_nx = count + 1'b1;
        idx_nx   = idx;
        sample   = 1'b0;

        case (state)
            ST_LATCH: begin
                if (count == LATCH_END) begin
                    state_nx = ST_FIRST;
                    count_nx = '0;
                end
            end

            ST_FIRST: begin
                sample = (count == '0); // pad shows A once latch drops
                if (count == HALF_END) begin
                    state_nx = ST_PULSE;
                    count_nx = '0;
                    idx_nx   = idx + 1'b1; // on to B
                end
            end

            ST_PULSE: begin
                // read at the end of the high phase
                sample = (count == HALF_END);
                if (count == LATCH_END) begin
                    count_nx = '0;
                    idx_nx   = idx + 1'b1; // right wraps back to A
                    if (idx == LAST_IDX) begin
                        state_nx = ST_LATCH;
                    end
                end
            end

            default: begin
                state_nx = ST_LATCH;
                count_nx = '0;
                idx_nx   = '0;
            end
        endcase
    end

    // outputs follow the state being entered, so the pins line up with state
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // park on the last cycle of the right slot
            // first poll then gets a full width latch
            state       <= ST_PULSE;
            count       <= LATCH_END;
            idx         <= LAST_IDX;
            nes_latch   <= 1'b0;
            nes_clk     <= 1'b0;
            nes_buttons <= '0; // all released
        end else begin
            state     <= state_nx;
            count     <= count_nx;
            idx       <= idx_nx;
            nes_latch <= (state_nx == ST_LATCH);
            nes_clk   <= (state_nx == ST_PULSE) && (count_nx <= HALF_END); // high phase

            if (sample) begin
                nes_buttons[idx] <= ~nes_data; // pad pulls low for pressed
            end
        end
    end

    // pad would see a clock edge while loading
    a_latch_clk_excl: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(nes_latch && nes_clk)
    ) else $error("nes_latch and nes_clk high together");

    a_clk_idle: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state inside {ST_LATCH, ST_FIRST}) |-> !nes_clk
    ) else $error("nes_clk high outside a pulse slot");

endmodule

/* hdl/gamepad_pkg.sv */
package gamepad_pkg;

    // nes poller states
    typedef enum logic [1:0] {
        ST_LATCH = 2'd0, // latch held high
        ST_FIRST = 2'd1, // clock low, bit A read on entry
        ST_PULSE = 2'd2  // one clock pulse per remaining button
    } poll_state_t;

    localparam int NES_BITS  = 8;  // classic pad buttons
    localparam int SNES_BITS = 12; // bits per pmod frame

    // pressed vector, 1 = pressed
    // A, B, select, start, up, down, left, right from bit 0 up
    typedef logic [NES_BITS-1:0] nes_buttons_t;

    // pmod frame as shifted in, 1 = pressed, all ones = no pad
    typedef logic [SNES_BITS-1:0] snes_frame_t;

    // frame bit positions, B arrives first and ends up on top
    localparam int SNES_IDX_B      = 11;
    localparam int SNES_IDX_Y      = 10;
    localparam int SNES_IDX_SELECT = 9;
    localparam int SNES_IDX_START  = 8;
    localparam int SNES_IDX_UP     = 7;
    localparam int SNES_IDX_DOWN   = 6;
    localparam int SNES_IDX_LEFT   = 5;
    localparam int SNES_IDX_RIGHT  = 4;
    localparam int SNES_IDX_A      = 3;
    localparam int SNES_IDX_X      = 2;
    localparam int SNES_IDX_L      = 1;
    localparam int SNES_IDX_R      = 0;

    // snes only buttons: X, Y, L, R from bit 0 up
    typedef logic [3:0] extra_buttons_t;

    // more pressed buttons than this is treated as a corrupt frame
    localparam int GHOST_LIMIT = 2;

endpackage
